/* soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // Bus widths
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    // All zero strobes mean a read
    typedef logic [3:0]  bus_strb_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    // Internal RAM, 4 KiB echoed up to the top of the space
    localparam bus_addr_t RAM_BASE   = 32'hFFFF_0000;
    localparam int        RAM_WORDS  = 1024;
    localparam int        RAM_IDX_W  = $clog2(RAM_WORDS);
    typedef logic [RAM_IDX_W-1:0] ram_index_t;

    // 256-byte GPIO window
    localparam bus_addr_t GPIO_BASE  = 32'h0300_0000;
    localparam bus_addr_t GPIO_LIMIT = 32'h0300_0100;
    // UART transmit data, a single word
    localparam bus_addr_t UART_ADDR  = 32'h0300_0100;

    // Read data for holes in the map
    localparam bus_data_t UNMAPPED_RDATA = '1;

    // ------------------------------------------------------------
    // GPIO register numbers, address bits 4 to 2
    // ------------------------------------------------------------
    typedef logic [2:0] gpio_off_t;
    localparam gpio_off_t GPIO_LED_GREEN = 3'd1;
    localparam gpio_off_t GPIO_LED_RED   = 3'd2;
    localparam gpio_off_t GPIO_SPI_CS    = 3'd3;
    localparam gpio_off_t GPIO_SPI_CLK   = 3'd4;
    localparam gpio_off_t GPIO_SPI_MOSI  = 3'd5;
    // Read only
    localparam gpio_off_t GPIO_SPI_MISO  = 3'd6;
    localparam gpio_off_t GPIO_USB_RST   = 3'd7;

    // UART 8N1, 10 bits per frame
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
    typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

`default_nettype wire

/* soc_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface soc_bus_if import soc_bus_pkg::*; ();

    // Request side, common to all targets
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;

    // Target selects, never more than one
    logic      ram_sel;
    logic      gpio_sel;
    logic      uart_sel;

    // Back from the targets
    bus_data_t ram_rdata;
    bus_data_t gpio_rdata;
    logic      uart_ready;

    modport decoder (
        output addr, wdata, wstrb,
        output ram_sel, gpio_sel, uart_sel,
        input  ram_rdata, gpio_rdata, uart_ready
    );

    modport ram (input addr, wdata, wstrb, ram_sel, output ram_rdata);

    modport gpio (input addr, wdata, wstrb, gpio_sel, output gpio_rdata);

    // UART only needs the low data byte and its select
    modport uart (input wdata, uart_sel, output uart_ready);

endinterface

`default_nettype wire

/* bus_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_decoder import soc_bus_pkg::*; (
    input  logic      clk_rv,
    input  logic      rst_rv,
    input  bus_addr_t mem_la_addr,
    input  logic      mem_valid,
    input  bus_addr_t mem_addr,
    input  bus_data_t mem_wdata,
    input  bus_strb_t mem_wstrb,
    output logic      mem_ready,
    output bus_data_t mem_rdata,
    output logic      irq_fault,
    soc_bus_if.decoder bus
);

    logic la_in_ram;
    logic la_in_gpio;
    logic la_in_uart;
    logic in_ram;
    logic in_gpio;
    logic in_uart;
    logic in_unmapped;
    logic first_cycle;
    logic default_ready;

    // ------------------------------------------------------------
    // Region decode on the lookahead address
    // ------------------------------------------------------------
    assign la_in_ram  = (mem_la_addr >= RAM_BASE);
    assign la_in_gpio = (mem_la_addr >= GPIO_BASE) && (mem_la_addr < GPIO_LIMIT);
    assign la_in_uart = (mem_la_addr == UART_ADDR);

    // Flags line up with the first cycle of mem_valid
    always_ff @(posedge clk_rv) begin
        in_ram      <= la_in_ram;
        in_gpio     <= la_in_gpio;
        in_uart     <= la_in_uart;
        in_unmapped <= !(la_in_ram || la_in_gpio || la_in_uart);
    end

    // Request seen, ack not yet given
    assign first_cycle = mem_valid && !mem_ready;

    assign bus.addr     = mem_addr;
    assign bus.wdata    = mem_wdata;
    assign bus.wstrb    = mem_wstrb;
    assign bus.ram_sel  = first_cycle && in_ram;
    assign bus.gpio_sel = first_cycle && in_gpio;
    // UART select held through back-pressure
    assign bus.uart_sel = mem_valid && in_uart;

    // ------------------------------------------------------------
    // Ready and read data
    // ------------------------------------------------------------
    // Fixed one-cycle ack for everything but the UART
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            default_ready <= 1'b0;
        end else begin
            default_ready <= first_cycle && !in_uart;
        end
    end

    assign mem_ready = default_ready || bus.uart_ready;

    assign mem_rdata = in_ram  ? bus.ram_rdata  :
                       in_gpio ? bus.gpio_rdata : UNMAPPED_RDATA;

    // Sticky until reset
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            irq_fault <= 1'b0;
        end else if (first_cycle && in_unmapped) begin
            irq_fault <= 1'b1;
        end
    end

    a_region_onehot: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        $onehot({in_ram, in_gpio, in_uart, in_unmapped}))
        else $error("Region flags not one-hot");

    // Covers the UART ack path as well
    a_ready_needs_valid: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        mem_ready |-> mem_valid)
        else $error("mem_ready without mem_valid");

endmodule

`default_nettype wire

/* word_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module word_ram import soc_bus_pkg::*; (
    input  logic   clk_rv,
    soc_bus_if.ram bus
);

    bus_data_t  mem [RAM_WORDS];
    ram_index_t idx;

    // Word index, upper address bits ignored so the RAM echoes
    assign idx = bus.addr[RAM_IDX_W+1:2];

    // ------------------------------------------------------------
    // Byte-strobed write
    // ------------------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (bus.ram_sel) begin
            for (int b = 0; b < 4; b++) begin
                // Only strobed lanes change
                if (bus.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Synchronous read
    // ------------------------------------------------------------
    // Valid in the ready cycle
    // old data returned on a same-cycle write
    always_ff @(posedge clk_rv) begin
        if (bus.ram_sel) begin
            bus.ram_rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* gpio_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module gpio_regs import soc_bus_pkg::*; (
    input  logic    clk_rv,
    input  logic    rst_rv,
    soc_bus_if.gpio bus,
    input  logic    spi_miso,
    output logic    led_green_n,
    output logic    led_red_n,
    output logic    spi_cs_n,
    output logic    spi_sck,
    output logic    spi_mosi,
    output logic    usb_rst_n
);

    gpio_off_t off;
    logic      led_green;
    logic      led_red;
    logic      is_write;

    // Register number from the word address
    assign off      = bus.addr[4:2];
    assign is_write = (bus.wstrb != '0);

    // ------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            led_green <= 1'b0;
            led_red   <= 1'b0;
            spi_cs_n  <= 1'b1;
            spi_sck   <= 1'b0;
            spi_mosi  <= 1'b0;
            // USB held in reset
            usb_rst_n <= 1'b0;
        end else if (bus.gpio_sel && is_write) begin
            case (off)
                GPIO_LED_GREEN: led_green <= bus.wdata[0];
                GPIO_LED_RED:   led_red   <= bus.wdata[0];
                GPIO_SPI_CS:    spi_cs_n  <= bus.wdata[0];
                GPIO_SPI_CLK:   spi_sck   <= bus.wdata[0];
                GPIO_SPI_MOSI:  spi_mosi  <= bus.wdata[0];
                GPIO_USB_RST:   usb_rst_n <= bus.wdata[0];
                // Offset 0 and MISO ignore writes
                default: ;
            endcase
        end
    end

    // LEDs are active low on the board
    assign led_green_n = !led_green;
    assign led_red_n   = !led_red;

    // ------------------------------------------------------------
    // Readback
    // ------------------------------------------------------------
    // Captured in the select cycle, presented with mem_ready
    always_ff @(posedge clk_rv) begin
        if (bus.gpio_sel && !is_write) begin
            if (off == GPIO_SPI_MISO) begin
                bus.gpio_rdata <= {31'd0, spi_miso};
            end else begin
                bus.gpio_rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx import soc_bus_pkg::*; (
    input  logic    clk_rv,
    input  logic    rst_rv,
    soc_bus_if.uart bus,
    output logic    uart_txd
);

    uart_state_t           state;
    logic [UART_CNT_W-1:0] clk_cnt;
    logic [2:0]            bit_cnt;
    logic [7:0]            shreg;
    logic                  bit_end;

    // Last cycle of the current bit time
    assign bit_end = (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1));

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state          <= UART_IDLE;
            clk_cnt        <= '0;
            bit_cnt        <= '0;
            uart_txd       <= 1'b1;
            bus.uart_ready <= 1'b0;
        end else begin
            // Ack is a single-cycle pulse
            bus.uart_ready <= 1'b0;
            clk_cnt        <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    clk_cnt <= '0;
                    // Accept only when idle, else master waits
                    if (bus.uart_sel) begin
                        shreg          <= bus.wdata[7:0];
                        uart_txd       <= 1'b0;
                        bus.uart_ready <= 1'b1;
                        state          <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        // LSB first
                        uart_txd <= shreg[0];
                        shreg    <= shreg >> 1;
                        bit_cnt  <= '0;
                        state    <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end && bit_cnt == 3'd7) begin
                        uart_txd <= 1'b1;
                        state    <= UART_STOP;
                    end else if (bit_end) begin
                        uart_txd <= shreg[0];
                        shreg    <= shreg >> 1;
                        bit_cnt  <= bit_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    // Line stays high into idle
                    if (bit_end) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (state == UART_IDLE) |-> uart_txd)
        else $error("uart_txd low while idle");

endmodule

`default_nettype wire

/* soc_fabric_top.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_top import soc_bus_pkg::*; (
    input  logic      clk_rv,
    input  logic      rst_rv,
    // CPU memory port
    input  bus_addr_t mem_la_addr,
    input  logic      mem_valid,
    input  bus_addr_t mem_addr,
    input  bus_data_t mem_wdata,
    input  bus_strb_t mem_wstrb,
    output logic      mem_ready,
    output bus_data_t mem_rdata,
    output logic      irq_fault,
    // Board pins
    input  logic      spi_miso,
    output logic      led_green_n,
    output logic      led_red_n,
    output logic      spi_cs_n,
    output logic      spi_sck,
    output logic      spi_mosi,
    output logic      usb_rst_n,
    output logic      uart_txd
);

    // ------------------------------------------------------------
    // Decoded bus to the targets
    // ------------------------------------------------------------
    soc_bus_if bus ();

    bus_decoder u_decoder (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_la_addr (mem_la_addr),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .irq_fault   (irq_fault),
        .bus         (bus.decoder)
    );

    // Internal RAM
    word_ram u_ram (
        .clk_rv (clk_rv),
        .bus    (bus.ram)
    );

    gpio_regs u_gpio (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .bus         (bus.gpio),
        .spi_miso    (spi_miso),
        .led_green_n (led_green_n),
        .led_red_n   (led_red_n),
        .spi_cs_n    (spi_cs_n),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .usb_rst_n   (usb_rst_n)
    );

    // Debug serial out
    uart_tx u_uart (
        .clk_rv   (clk_rv),
        .rst_rv   (rst_rv),
        .bus      (bus.uart),
        .uart_txd (uart_txd)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk_rv,
    output logic rst_rv
);

    // 100 ns period
    localparam int HALF_PERIOD   = 50;
    localparam int RESET_CYCLES  = 2;
    // Release lines up with the stimulus delay
    localparam int RELEASE_DELAY = 10;

    initial begin
        clk_rv = 1'b0;
        forever begin
            #HALF_PERIOD clk_rv = ~clk_rv;
        end
    end

    // Active low reset over the first two rising edges
    initial begin
        rst_rv = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_rv);
        #RELEASE_DELAY;
        rst_rv = 1'b1;
    end

endmodule

`default_nettype wire

/* soc_fabric_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_checker import soc_bus_pkg::*; (
    input  logic      clk_rv,
    input  logic      rst_rv,
    input  logic      mem_valid,
    input  bus_addr_t mem_addr,
    input  bus_data_t mem_wdata,
    input  bus_strb_t mem_wstrb,
    input  logic      mem_ready,
    input  bus_data_t mem_rdata,
    input  logic      irq_fault,
    input  logic      spi_miso,
    input  logic      led_green_n,
    input  logic      led_red_n,
    input  logic      spi_cs_n,
    input  logic      spi_sck,
    input  logic      spi_mosi,
    input  logic      usb_rst_n,
    input  logic      uart_txd,
    output int        bus_errors,
    output int        uart_errors,
    output int        reset_errors,
    output int        acks_seen,
    output int        frames_pending
);

    // mem_ready, irq_fault, uart_txd, then the six GPIO pins
    localparam logic [8:0] RESET_OUTPUTS = 9'b0_0_1_1_1_1_0_0_0;

    // RAM model with one known flag per byte lane
    bus_data_t  ram_model [RAM_WORDS] = '{default: '0};
    bus_strb_t  ram_known [RAM_WORDS] = '{default: '0};
    // Pin order green_n, red_n, cs_n, sck, mosi, usb_rst_n
    logic [5:0] pins_model  = 6'b111000;
    logic       fault_model = 1'b0;
    // Bytes waiting to show up on the serial line
    logic [7:0] uart_bytes [256];
    int         frames_queued;
    int         frames_checked;
    // Valid cycles without ready in the current access
    int         wait_cycles;

    assign frames_pending = frames_queued - frames_checked;

    // Byte strobes widened to a bit mask
    function automatic bus_data_t strb_mask(input bus_strb_t s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // ------------------------------------------------------------
    // Bus accesses against the model
    // ------------------------------------------------------------
    task automatic check_access();
        ram_index_t idx;
        gpio_off_t  off;
        bus_data_t  smask;
        bus_data_t  kmask;
        bus_data_t  exp;
        logic       is_write;
        idx      = mem_addr[11:2];
        off      = mem_addr[4:2];
        is_write = (mem_wstrb != 4'h0);
        smask    = strb_mask(mem_wstrb);
        // Fixed one-cycle wait for everything but the UART
        if (mem_addr != UART_ADDR && wait_cycles != 1) begin
            bus_errors++;
            $display("FAIL %0t: ready for %h after %0d wait cycles expected 1",
                     $time, mem_addr, wait_cycles);
        end
        if (mem_addr >= RAM_BASE) begin
            if (is_write) begin
                ram_model[idx] = (ram_model[idx] & ~smask) | (mem_wdata & smask);
                ram_known[idx] = ram_known[idx] | mem_wstrb;
            end else begin
                // Bytes never written are not compared
                kmask = strb_mask(ram_known[idx]);
                if ((mem_rdata & kmask) !== (ram_model[idx] & kmask)) begin
                    bus_errors++;
                    $display("FAIL %0t: RAM read %h got %h expected %h mask %h",
                             $time, mem_addr, mem_rdata, ram_model[idx], kmask);
                end
            end
        end else if (mem_addr >= GPIO_BASE && mem_addr < GPIO_LIMIT) begin
            if (is_write) begin
                case (off)
                    GPIO_LED_GREEN: pins_model[5] = ~mem_wdata[0];
                    GPIO_LED_RED:   pins_model[4] = ~mem_wdata[0];
                    GPIO_SPI_CS:    pins_model[3] = mem_wdata[0];
                    GPIO_SPI_CLK:   pins_model[2] = mem_wdata[0];
                    GPIO_SPI_MOSI:  pins_model[1] = mem_wdata[0];
                    GPIO_USB_RST:   pins_model[0] = mem_wdata[0];
                    default: ;
                endcase
            end else begin
                exp = (off == GPIO_SPI_MISO) ? {31'd0, spi_miso} : '0;
                if (mem_rdata !== exp) begin
                    bus_errors++;
                    $display("FAIL %0t: GPIO read %h got %h expected %h",
                             $time, mem_addr, mem_rdata, exp);
                end
            end
        end else if (mem_addr == UART_ADDR) begin
            // Only writes go to the UART
            uart_bytes[frames_queued[7:0]] = mem_wdata[7:0];
            frames_queued++;
        end else begin
            fault_model = 1'b1;
            if (!is_write && mem_rdata !== UNMAPPED_RDATA) begin
                bus_errors++;
                $display("FAIL %0t: unmapped read %h got %h expected %h",
                         $time, mem_addr, mem_rdata, UNMAPPED_RDATA);
            end
        end
    endtask

    // Pins and fault flag checked every cycle
    task automatic check_outputs();
        if ({led_green_n, led_red_n, spi_cs_n, spi_sck, spi_mosi, usb_rst_n} !== pins_model) begin
            bus_errors++;
            $display("FAIL %0t: GPIO pins %b expected %b", $time,
                     {led_green_n, led_red_n, spi_cs_n, spi_sck, spi_mosi, usb_rst_n},
                     pins_model);
        end
        if (irq_fault !== fault_model) begin
            bus_errors++;
            $display("FAIL %0t: irq_fault %b expected %b", $time, irq_fault, fault_model);
        end
    endtask

    // Sampled on the falling edge clear of DUT updates
    always @(negedge clk_rv) begin
        if (rst_rv === 1'b1) begin
            // Every ready pulse counts, stray ones included
            if (mem_ready === 1'b1) begin
                acks_seen++;
            end
            if (mem_valid === 1'b1 && mem_ready === 1'b1) begin
                check_access();
                wait_cycles = 0;
            end else if (mem_valid === 1'b1) begin
                wait_cycles++;
            end
            check_outputs();
        end
    end

    initial begin : reset_check
        logic [8:0] got;
        wait (rst_rv === 1'b1);
        @(negedge clk_rv);
        got = {mem_ready, irq_fault, uart_txd, led_green_n, led_red_n,
               spi_cs_n, spi_sck, spi_mosi, usb_rst_n};
        if (got !== RESET_OUTPUTS) begin
            reset_errors++;
            $display("FAIL %0t: outputs after reset %b expected %b", $time, got, RESET_OUTPUTS);
        end
    end

    // ------------------------------------------------------------
    // Serial frame receiver
    // ------------------------------------------------------------
    initial begin : uart_monitor
        logic [7:0] got;
        logic [7:0] exp;
        wait (rst_rv === 1'b1);
        forever begin
            @(negedge clk_rv);
            if (uart_txd === 1'b0) begin
                // Middle of the start bit
                repeat (UART_CLKS_PER_BIT / 2) @(negedge clk_rv);
                if (uart_txd !== 1'b0) begin
                    uart_errors++;
                    $display("FAIL %0t: start bit not low at mid-bit", $time);
                end
                // LSB first so bits shift in from the top
                for (int k = 0; k < 8; k++) begin
                    repeat (UART_CLKS_PER_BIT) @(negedge clk_rv);
                    got = {uart_txd, got[7:1]};
                end
                repeat (UART_CLKS_PER_BIT) @(negedge clk_rv);
                if (uart_txd !== 1'b1) begin
                    uart_errors++;
                    $display("FAIL %0t: stop bit not high", $time);
                end
                if (frames_checked >= frames_queued) begin
                    uart_errors++;
                    $display("UART frame seen at %0t with no byte written", $time);
                end else begin
                    exp = uart_bytes[frames_checked[7:0]];
                    if (got !== exp) begin
                        uart_errors++;
                        $display("FAIL %0t: UART frame %h expected %h", $time, got, exp);
                    end
                end
                frames_checked++;
            end
        end
    end

endmodule

`default_nettype wire

/* soc_fabric_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_tb import soc_bus_pkg::*; ();

    localparam int N_TRANS     = 200;
    localparam int MAX_UART    = 40;
    localparam int DRIVE_DELAY = 10;
    localparam int RAND_SEED   = 7;
    // Four cycles per access, one frame plus slack per UART write, then margin
    localparam int TIMEOUT_CYCLES = N_TRANS * 4 + MAX_UART * (UART_CLKS_PER_BIT * 10 + 10) + 600;

    logic      clk_rv;
    logic      rst_rv;
    bus_addr_t mem_la_addr;
    logic      mem_valid;
    bus_addr_t mem_addr;
    bus_data_t mem_wdata;
    bus_strb_t mem_wstrb;
    logic      mem_ready;
    bus_data_t mem_rdata;
    logic      irq_fault;
    logic      spi_miso;
    logic      led_green_n;
    logic      led_red_n;
    logic      spi_cs_n;
    logic      spi_sck;
    logic      spi_mosi;
    logic      usb_rst_n;
    logic      uart_txd;

    int bus_errors;
    int uart_errors;
    int reset_errors;
    int run_errors;
    int acks_seen;
    int frames_pending;
    int uart_writes;
    int cycle_count = 0;

    tb_clock u_clock (
        .clk_rv (clk_rv),
        .rst_rv (rst_rv)
    );

    soc_fabric_top UUT (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_la_addr (mem_la_addr),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .irq_fault   (irq_fault),
        .spi_miso    (spi_miso),
        .led_green_n (led_green_n),
        .led_red_n   (led_red_n),
        .spi_cs_n    (spi_cs_n),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .usb_rst_n   (usb_rst_n),
        .uart_txd    (uart_txd)
    );

    soc_fabric_checker u_checker (
        .clk_rv         (clk_rv),
        .rst_rv         (rst_rv),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_wstrb      (mem_wstrb),
        .mem_ready      (mem_ready),
        .mem_rdata      (mem_rdata),
        .irq_fault      (irq_fault),
        .spi_miso       (spi_miso),
        .led_green_n    (led_green_n),
        .led_red_n      (led_red_n),
        .spi_cs_n       (spi_cs_n),
        .spi_sck        (spi_sck),
        .spi_mosi       (spi_mosi),
        .usb_rst_n      (usb_rst_n),
        .uart_txd       (uart_txd),
        .bus_errors     (bus_errors),
        .uart_errors    (uart_errors),
        .reset_errors   (reset_errors),
        .acks_seen      (acks_seen),
        .frames_pending (frames_pending)
    );

    // ------------------------------------------------------------
    // Bus master
    // ------------------------------------------------------------
    // Entered 10 ns after a rising edge with mem_valid low
    task automatic run_access(input bus_addr_t addr, input bus_data_t wdata,
                              input bus_strb_t wstrb);
        // Lookahead cycle, MISO only moves here
        mem_la_addr = addr;
        spi_miso    = 1'($urandom);
        @(posedge clk_rv);
        #DRIVE_DELAY;
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        // Ready sampled mid-cycle
        do begin
            @(negedge clk_rv);
        end while (mem_ready !== 1'b1);
        @(posedge clk_rv);
        #DRIVE_DELAY;
        mem_valid = 1'b0;
        mem_wstrb = '0;
    endtask

    task automatic run_random_access();
        int unsigned pick;
        int unsigned hole;
        bus_addr_t   addr;
        bus_data_t   wdata;
        bus_strb_t   wstrb;
        logic        is_write;
        pick     = $urandom_range(99, 0);
        hole     = $urandom_range(2, 0);
        wdata    = bus_data_t'($urandom);
        is_write = 1'($urandom);
        wstrb    = is_write ? bus_strb_t'($urandom_range(15, 1)) : 4'h0;
        // UART budget spent, becomes a RAM access
        if (pick >= 65 && pick < 85 && uart_writes >= MAX_UART) begin
            pick = 0;
        end
        if (pick < 40) begin
            // Random 4 KiB page over few words, so echoes hit
            addr = RAM_BASE | {16'h0000, 4'($urandom), ram_index_t'($urandom_range(31, 0)),
                               2'b00};
        end else if (pick < 65) begin
            addr = GPIO_BASE | {24'h00_0000, 6'($urandom), 2'b00};
        end else if (pick < 85) begin
            addr  = UART_ADDR;
            wstrb = 4'h1;
            uart_writes++;
        end else begin
            // Holes below GPIO, just past the UART, and high up
            case (hole)
                0:       addr = {8'h00, 24'($urandom)};
                1:       addr = UART_ADDR + 32'd4 + {24'h00_0000, 6'($urandom), 2'b00};
                default: addr = {8'h80, 24'($urandom)};
            endcase
        end
        run_access(addr, wdata, wstrb);
    endtask

    initial begin : master
        int unsigned seed_ret;
        int          total;
        mem_la_addr = '0;
        mem_valid   = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_wstrb   = '0;
        spi_miso    = 1'b0;
        run_errors  = 0;
        uart_writes = 0;
        seed_ret    = $urandom(RAND_SEED);
        wait (rst_rv === 1'b1);
        @(posedge clk_rv);
        #DRIVE_DELAY;
        for (int n = 0; n < N_TRANS; n++) begin
            run_random_access();
        end
        // Let queued frames drain off the line
        while (frames_pending != 0) begin
            @(posedge clk_rv);
        end
        repeat (4) @(posedge clk_rv);
        if (acks_seen != N_TRANS) begin
            run_errors++;
            $display("Acknowledge count %0d differs from %0d issued accesses",
                     acks_seen, N_TRANS);
        end
        total = bus_errors + uart_errors + reset_errors + run_errors;
        $display("Errors: bus %0d, uart %0d, reset %0d, run %0d, total %0d",
                 bus_errors, uart_errors, reset_errors, run_errors, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------
    always @(posedge clk_rv) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, %0d accesses acknowledged, %0d frames pending",
                 cycle_count, acks_seen, frames_pending);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* soc_fabric_top.f */
soc_bus_pkg.sv
soc_bus_if.sv
bus_decoder.sv
word_ram.sv
gpio_regs.sv
uart_tx.sv
soc_fabric_top.sv
tb_clock.sv
soc_fabric_checker.sv
soc_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module soc_fabric_tb -o soc_fabric_sim \
    -f soc_fabric_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/soc_fabric_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
